//--- rtl/mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [15:0] imm16_t;
    typedef logic [5:0]  mem_addr_t;

    localparam int NUM_REGS   = 32;
    localparam int DMEM_WORDS = 64;

    // Opcode field.
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_HALT  = 6'h3f;

    // Function field of R-type instructions.
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

    // ALU operations, kept contiguous from zero.
    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_NOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_LUI = 4'd9;

endpackage

//--- rtl/mips_pipe_pkg.sv
package mips_pipe_pkg;

    // Operand source in the execute stage.
    typedef logic [1:0] fwd_sel_t;

    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    //////////////////////////////
    // Stage bundles.
    //////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   mem_to_reg;
        logic                   alu_src;
        logic                   halt;
        mips_isa_pkg::alu_op_t  alu_op;
        mips_isa_pkg::reg_idx_t rs;
        mips_isa_pkg::reg_idx_t rt;
        mips_isa_pkg::reg_idx_t rd;
        mips_isa_pkg::word_t    rs_data;
        mips_isa_pkg::word_t    rt_data;
        mips_isa_pkg::word_t    imm;
        logic                   dest_is_rd;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   mem_to_reg;
        logic                   halt;
        mips_isa_pkg::word_t    result;
        mips_isa_pkg::word_t    store_data;
        mips_isa_pkg::reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic                   reg_write;
        logic                   halt;
        mips_isa_pkg::word_t    wb_data;
        mips_isa_pkg::reg_idx_t dest;
    } mem_wb_t;

endpackage

//--- rtl/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    input  logic                   i_enable_pipeline,
    input  logic                   i_instr_valid,
    input  mips_isa_pkg::word_t    i_instr,
    input  mips_isa_pkg::word_t    i_rs_data,
    input  mips_isa_pkg::word_t    i_rt_data,
    output mips_isa_pkg::reg_idx_t o_rs,
    output mips_isa_pkg::reg_idx_t o_rt,
    output mips_pipe_pkg::id_ex_t  o_id_ex
);

    mips_isa_pkg::opcode_t  opcode;
    mips_isa_pkg::funct_t   funct;
    mips_isa_pkg::reg_idx_t rd;
    mips_isa_pkg::imm16_t   imm16;
    logic                   sign_ext;
    logic                   legal;
    mips_pipe_pkg::id_ex_t  id_ex_next;

    assign opcode = i_instr[31:26];
    assign o_rs   = i_instr[25:21];
    assign o_rt   = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign funct  = i_instr[5:0];
    assign imm16  = i_instr[15:0];

    // Arithmetic and memory immediates are signed, logical ones are not.
    assign sign_ext = opcode inside {mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_SLTI,
                                     mips_isa_pkg::OP_LW, mips_isa_pkg::OP_SW};

    always_comb begin
        id_ex_next           = '0;
        id_ex_next.rs        = o_rs;
        id_ex_next.rt        = o_rt;
        id_ex_next.rd        = rd;
        id_ex_next.rs_data   = i_rs_data;
        id_ex_next.rt_data   = i_rt_data;
        id_ex_next.imm       = {{16{sign_ext & imm16[15]}}, imm16};
        id_ex_next.alu_src   = (opcode != mips_isa_pkg::OP_RTYPE);
        id_ex_next.reg_write = !(opcode inside {mips_isa_pkg::OP_SW, mips_isa_pkg::OP_HALT});
        legal                = 1'b1;
        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                id_ex_next.dest_is_rd = 1'b1;
                case (funct)
                    mips_isa_pkg::FN_ADDU: id_ex_next.alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: id_ex_next.alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  id_ex_next.alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   id_ex_next.alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_XOR:  id_ex_next.alu_op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::FN_NOR:  id_ex_next.alu_op = mips_isa_pkg::ALU_NOR;
                    mips_isa_pkg::FN_SLT:  id_ex_next.alu_op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLLV: id_ex_next.alu_op = mips_isa_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRLV: id_ex_next.alu_op = mips_isa_pkg::ALU_SRL;
                    default:               legal = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDI: id_ex_next.alu_op = mips_isa_pkg::ALU_ADD;
            mips_isa_pkg::OP_SLTI: id_ex_next.alu_op = mips_isa_pkg::ALU_SLT;
            mips_isa_pkg::OP_ANDI: id_ex_next.alu_op = mips_isa_pkg::ALU_AND;
            mips_isa_pkg::OP_ORI:  id_ex_next.alu_op = mips_isa_pkg::ALU_OR;
            mips_isa_pkg::OP_XORI: id_ex_next.alu_op = mips_isa_pkg::ALU_XOR;
            mips_isa_pkg::OP_LUI:  id_ex_next.alu_op = mips_isa_pkg::ALU_LUI;
            mips_isa_pkg::OP_LW: begin
                id_ex_next.mem_read   = 1'b1;
                id_ex_next.mem_to_reg = 1'b1;
            end
            mips_isa_pkg::OP_SW:   id_ex_next.mem_write = 1'b1;
            mips_isa_pkg::OP_HALT: id_ex_next.halt = 1'b1;
            default:               legal = 1'b0;
        endcase
        // A write to register 0 is turned into a no-op.
        if ((id_ex_next.dest_is_rd ? rd : o_rt) == '0) begin
            id_ex_next.reg_write = 1'b0;
        end
        id_ex_next.valid = i_instr_valid && legal;
        if (!id_ex_next.valid) begin
            id_ex_next.reg_write = 1'b0;
            id_ex_next.mem_read  = 1'b0;
            id_ex_next.mem_write = 1'b0;
            id_ex_next.halt      = 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_id_ex <= '0;
        end else if (i_enable_pipeline) begin
            o_id_ex <= id_ex_next;
        end
    end

    // The instruction source only issues supported encodings.
    a_known_opcode: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        (i_instr_valid && i_enable_pipeline) |-> legal);

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    input  logic                   i_enable_pipeline,
    input  mips_isa_pkg::reg_idx_t i_rs,
    input  mips_isa_pkg::reg_idx_t i_rt,
    input  mips_pipe_pkg::mem_wb_t i_mem_wb,
    output mips_isa_pkg::word_t    o_rs_data,
    output mips_isa_pkg::word_t    o_rt_data
);

    mips_isa_pkg::word_t regs [mips_isa_pkg::NUM_REGS];
    logic                wr_en;

    assign wr_en = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dest != '0);

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int i = 0; i < mips_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_enable_pipeline && wr_en) begin
            regs[i_mem_wb.dest] <= i_mem_wb.wb_data;
        end
    end

    // Write-through, so decode sees a value in the cycle it is written.
    assign o_rs_data = (i_rs == '0) ? '0 :
                       (wr_en && (i_rs == i_mem_wb.dest)) ? i_mem_wb.wb_data : regs[i_rs];
    assign o_rt_data = (i_rt == '0) ? '0 :
                       (wr_en && (i_rt == i_mem_wb.dest)) ? i_mem_wb.wb_data : regs[i_rt];

endmodule

//--- rtl/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
    input  mips_pipe_pkg::id_ex_t    i_id_ex,
    input  mips_pipe_pkg::ex_mem_t   i_ex_mem,
    input  mips_pipe_pkg::mem_wb_t   i_mem_wb,
    output mips_pipe_pkg::fwd_sel_t  o_fwd_a,
    output mips_pipe_pkg::fwd_sel_t  o_fwd_b
);

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    assign mem_fwd_ok = i_ex_mem.valid && i_ex_mem.reg_write && (i_ex_mem.dest != '0);
    assign wb_fwd_ok  = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dest != '0);

    // The younger producer in EX/MEM wins over MEM/WB.
    function automatic mips_pipe_pkg::fwd_sel_t select_src(
        input mips_isa_pkg::reg_idx_t src
    );
        if (mem_fwd_ok && (src == i_ex_mem.dest)) begin
            return mips_pipe_pkg::FWD_MEM;
        end else if (wb_fwd_ok && (src == i_mem_wb.dest)) begin
            return mips_pipe_pkg::FWD_WB;
        end
        return mips_pipe_pkg::FWD_NONE;
    endfunction

    always_comb begin
        o_fwd_a = select_src(i_id_ex.rs);
        o_fwd_b = select_src(i_id_ex.rt);
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  mips_isa_pkg::alu_op_t i_alu_op,
    input  mips_isa_pkg::word_t   i_operand_a,
    input  mips_isa_pkg::word_t   i_operand_b,
    output mips_isa_pkg::word_t   o_result
);

    logic less_signed;

    assign less_signed = $signed(i_operand_a) < $signed(i_operand_b);

    always_comb begin
        case (i_alu_op)
            mips_isa_pkg::ALU_ADD: o_result = i_operand_a + i_operand_b;
            mips_isa_pkg::ALU_SUB: o_result = i_operand_a - i_operand_b;
            mips_isa_pkg::ALU_AND: o_result = i_operand_a & i_operand_b;
            mips_isa_pkg::ALU_OR:  o_result = i_operand_a | i_operand_b;
            mips_isa_pkg::ALU_XOR: o_result = i_operand_a ^ i_operand_b;
            mips_isa_pkg::ALU_NOR: o_result = ~(i_operand_a | i_operand_b);
            mips_isa_pkg::ALU_SLT: o_result = {{31{1'b0}}, less_signed};
            // Variable shifts, amount from the low bits of A.
            mips_isa_pkg::ALU_SLL: o_result = i_operand_b << i_operand_a[4:0];
            mips_isa_pkg::ALU_SRL: o_result = i_operand_b >> i_operand_a[4:0];
            mips_isa_pkg::ALU_LUI: o_result = {i_operand_b[15:0], 16'h0000};
            default:               o_result = '0;
        endcase
    end

    // Decode only produces the defined operations.
    always_comb begin
        a_defined_op: assert final ($isunknown(i_alu_op) ||
            (i_alu_op inside {[mips_isa_pkg::ALU_ADD : mips_isa_pkg::ALU_LUI]}));
    end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                    i_clock,
    input  logic                    i_soft_reset,
    input  logic                    i_enable_pipeline,
    input  mips_pipe_pkg::id_ex_t   i_id_ex,
    input  mips_pipe_pkg::fwd_sel_t i_fwd_a,
    input  mips_pipe_pkg::fwd_sel_t i_fwd_b,
    input  mips_isa_pkg::word_t     i_wb_data,
    output mips_pipe_pkg::ex_mem_t  o_ex_mem
);

    mips_isa_pkg::word_t    operand_a;
    mips_isa_pkg::word_t    fwd_b_data;
    mips_isa_pkg::word_t    operand_b;
    mips_isa_pkg::word_t    alu_result;
    mips_isa_pkg::reg_idx_t dest;

    function automatic mips_isa_pkg::word_t fwd_mux(
        input mips_pipe_pkg::fwd_sel_t sel,
        input mips_isa_pkg::word_t     normal,
        input mips_isa_pkg::word_t     from_mem,
        input mips_isa_pkg::word_t     from_wb
    );
        case (sel)
            mips_pipe_pkg::FWD_MEM: return from_mem;
            mips_pipe_pkg::FWD_WB:  return from_wb;
            default:                return normal;
        endcase
    endfunction

    //////////////////////////////
    // Operand selection.
    //////////////////////////////

    // The MEM value is this stage's own registered result.
    assign operand_a  = fwd_mux(i_fwd_a, i_id_ex.rs_data, o_ex_mem.result, i_wb_data);
    assign fwd_b_data = fwd_mux(i_fwd_b, i_id_ex.rt_data, o_ex_mem.result, i_wb_data);
    assign operand_b  = i_id_ex.alu_src ? i_id_ex.imm : fwd_b_data;
    assign dest       = i_id_ex.dest_is_rd ? i_id_ex.rd : i_id_ex.rt;

    alu u_alu (
        .i_alu_op    (i_id_ex.alu_op),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .o_result    (alu_result)
    );

    //////////////////////////////
    // EX/MEM register.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_ex_mem <= '0;
        end else if (i_enable_pipeline) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.mem_to_reg <= i_id_ex.mem_to_reg;
            o_ex_mem.halt       <= i_id_ex.halt;
            o_ex_mem.result     <= alu_result;
            o_ex_mem.store_data <= fwd_b_data;
            o_ex_mem.dest       <= dest;
        end
    end

endmodule

//--- rtl/memory_writeback.sv
`timescale 1ns/1ns

module memory_writeback (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    input  logic                   i_enable_pipeline,
    input  mips_pipe_pkg::ex_mem_t i_ex_mem,
    output mips_pipe_pkg::mem_wb_t o_mem_wb
);

    mips_isa_pkg::word_t     dmem [mips_isa_pkg::DMEM_WORDS];
    mips_isa_pkg::mem_addr_t addr;
    mips_isa_pkg::word_t     load_data;

    // Word index from the byte address.
    assign addr      = i_ex_mem.result[7:2];
    assign load_data = dmem[addr];

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            for (int i = 0; i < mips_isa_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_enable_pipeline && i_ex_mem.valid && i_ex_mem.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    //////////////////////////////
    // MEM/WB register.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_mem_wb <= '0;
        end else if (i_enable_pipeline) begin
            o_mem_wb.valid     <= i_ex_mem.valid;
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
            o_mem_wb.halt      <= i_ex_mem.halt;
            o_mem_wb.wb_data   <= i_ex_mem.mem_to_reg ? load_data : i_ex_mem.result;
            o_mem_wb.dest      <= i_ex_mem.dest;
        end
    end

    // Loads and stores computed in execute are word aligned.
    a_word_aligned: assert property (@(posedge i_clock) disable iff (!i_soft_reset)
        (i_ex_mem.valid && (i_ex_mem.mem_read || i_ex_mem.mem_write))
            |-> (i_ex_mem.result[1:0] == 2'b00));

endmodule

//--- rtl/mips_exec_pipeline.sv
`timescale 1ns/1ns

module mips_exec_pipeline (
    input  logic                   i_clock,
    input  logic                   i_soft_reset,
    input  logic                   i_enable_pipeline,
    input  logic                   i_instr_valid,
    input  mips_isa_pkg::word_t    i_instr,
    output logic                   o_wb_valid,
    output mips_isa_pkg::reg_idx_t o_wb_dest,
    output mips_isa_pkg::word_t    o_wb_data,
    output logic                   o_halt
);

    mips_isa_pkg::reg_idx_t  rs;
    mips_isa_pkg::reg_idx_t  rt;
    mips_isa_pkg::word_t     rs_data;
    mips_isa_pkg::word_t     rt_data;
    mips_pipe_pkg::id_ex_t   id_ex;
    mips_pipe_pkg::ex_mem_t  ex_mem;
    mips_pipe_pkg::mem_wb_t  mem_wb;
    mips_pipe_pkg::fwd_sel_t fwd_a;
    mips_pipe_pkg::fwd_sel_t fwd_b;

    instr_decode u_instr_decode (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_instr_valid     (i_instr_valid),
        .i_instr           (i_instr),
        .i_rs_data         (rs_data),
        .i_rt_data         (rt_data),
        .o_rs              (rs),
        .o_rt              (rt),
        .o_id_ex           (id_ex)
    );

    register_file u_register_file (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_rs              (rs),
        .i_rt              (rt),
        .i_mem_wb          (mem_wb),
        .o_rs_data         (rs_data),
        .o_rt_data         (rt_data)
    );

    forwarding_unit u_forwarding_unit (
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_mem_wb (mem_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b)
    );

    execute_stage u_execute_stage (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_id_ex           (id_ex),
        .i_fwd_a           (fwd_a),
        .i_fwd_b           (fwd_b),
        .i_wb_data         (mem_wb.wb_data),
        .o_ex_mem          (ex_mem)
    );

    memory_writeback u_memory_writeback (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_ex_mem          (ex_mem),
        .o_mem_wb          (mem_wb)
    );

    assign o_wb_valid = mem_wb.valid && mem_wb.reg_write;
    assign o_wb_dest  = mem_wb.dest;
    assign o_wb_data  = mem_wb.wb_data;
    assign o_halt     = mem_wb.valid && mem_wb.halt;

endmodule

//--- testbench/tb_mips_exec_pipeline.sv
`timescale 1ns/1ns

module tb_mips_exec_pipeline;

    logic                   i_clock;
    logic                   i_soft_reset;
    logic                   i_enable_pipeline;
    logic                   i_instr_valid;
    mips_isa_pkg::word_t    i_instr;
    logic                   o_wb_valid;
    mips_isa_pkg::reg_idx_t o_wb_dest;
    mips_isa_pkg::word_t    o_wb_data;
    logic                   o_halt;

    integer seed;
    int     issued;
    int     stalled;
    int     mismatches;
    int     other_errors;
    bit     stall_on;
    bit     halt_issued;
    string  test_name;

    mips_isa_pkg::word_t    model_regs [mips_isa_pkg::NUM_REGS];
    mips_isa_pkg::word_t    model_mem [mips_isa_pkg::DMEM_WORDS];
    mips_isa_pkg::reg_idx_t exp_dest_q [$];
    mips_isa_pkg::word_t    exp_data_q [$];
    string                  exp_name_q [$];

    mips_isa_pkg::funct_t  functs [9] = '{mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUBU,
        mips_isa_pkg::FN_AND, mips_isa_pkg::FN_OR, mips_isa_pkg::FN_XOR, mips_isa_pkg::FN_NOR,
        mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV};
    mips_isa_pkg::opcode_t imm_ops [6] = '{mips_isa_pkg::OP_ADDI, mips_isa_pkg::OP_SLTI,
        mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI, mips_isa_pkg::OP_LUI};

    mips_exec_pipeline i_dut (
        .i_clock           (i_clock),
        .i_soft_reset      (i_soft_reset),
        .i_enable_pipeline (i_enable_pipeline),
        .i_instr_valid     (i_instr_valid),
        .i_instr           (i_instr),
        .o_wb_valid        (o_wb_valid),
        .o_wb_dest         (o_wb_dest),
        .o_wb_data         (o_wb_data),
        .o_halt            (o_halt)
    );

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;
    end

    function automatic mips_isa_pkg::word_t r_format(input mips_isa_pkg::funct_t fn,
        input mips_isa_pkg::reg_idx_t rd, input mips_isa_pkg::reg_idx_t rs,
        input mips_isa_pkg::reg_idx_t rt);
        return {mips_isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_isa_pkg::word_t i_format(input mips_isa_pkg::opcode_t op,
        input mips_isa_pkg::reg_idx_t rt, input mips_isa_pkg::reg_idx_t rs,
        input mips_isa_pkg::imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mips_isa_pkg::reg_idx_t pick_reg();
        return mips_isa_pkg::reg_idx_t'(1 + ($unsigned($random(seed)) % 15));
    endfunction

    //////////////////////////////
    // Sequential reference model.
    //////////////////////////////

    function automatic bit model_exec(input mips_isa_pkg::word_t instr,
        output mips_isa_pkg::reg_idx_t dest, output mips_isa_pkg::word_t value);
        mips_isa_pkg::word_t a;
        mips_isa_pkg::word_t b;
        mips_isa_pkg::word_t sext;
        mips_isa_pkg::word_t zext;
        mips_isa_pkg::word_t addr;
        bit                  writes;
        a      = model_regs[instr[25:21]];
        b      = model_regs[instr[20:16]];
        sext   = {{16{instr[15]}}, instr[15:0]};
        zext   = {16'h0000, instr[15:0]};
        addr   = a + sext;
        dest   = instr[20:16];
        value  = '0;
        writes = 1'b1;
        case (instr[31:26])
            mips_isa_pkg::OP_RTYPE: begin
                dest = instr[15:11];
                case (instr[5:0])
                    mips_isa_pkg::FN_ADDU: value = a + b;
                    mips_isa_pkg::FN_SUBU: value = a - b;
                    mips_isa_pkg::FN_AND:  value = a & b;
                    mips_isa_pkg::FN_OR:   value = a | b;
                    mips_isa_pkg::FN_XOR:  value = a ^ b;
                    mips_isa_pkg::FN_NOR:  value = ~(a | b);
                    mips_isa_pkg::FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mips_isa_pkg::FN_SLLV: value = b << a[4:0];
                    mips_isa_pkg::FN_SRLV: value = b >> a[4:0];
                    default:               writes = 1'b0;
                endcase
            end
            mips_isa_pkg::OP_ADDI: value = a + sext;
            mips_isa_pkg::OP_SLTI: value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            mips_isa_pkg::OP_ANDI: value = a & zext;
            mips_isa_pkg::OP_ORI:  value = a | zext;
            mips_isa_pkg::OP_XORI: value = a ^ zext;
            mips_isa_pkg::OP_LUI:  value = {instr[15:0], 16'h0000};
            mips_isa_pkg::OP_LW:   value = model_mem[addr[7:2]];
            mips_isa_pkg::OP_SW: begin
                model_mem[addr[7:2]] = b;
                writes = 1'b0;
            end
            default:               writes = 1'b0;
        endcase
        // Register 0 is never written.
        if (dest == 5'd0) begin
            writes = 1'b0;
        end
        if (writes) begin
            model_regs[dest] = value;
        end
        return writes;
    endfunction

    task automatic check_dest(input string name, input mips_isa_pkg::reg_idx_t expected,
        input mips_isa_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s at %0t: dest expected r%0d, actual r%0d",
                     name, $time, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_data(input string name, input mips_isa_pkg::word_t expected,
        input mips_isa_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s at %0t: data expected %h, actual %h",
                     name, $time, expected, actual);
            mismatches++;
        end
    endtask

    // Drives one instruction, with optional stall cycles before it.
    task automatic issue(input mips_isa_pkg::word_t instr);
        mips_isa_pkg::reg_idx_t dest;
        mips_isa_pkg::word_t    value;
        int                     gap;
        gap = 0;
        if (stall_on && (($random(seed) & 3) == 0)) begin
            gap = 1 + ($unsigned($random(seed)) % 3);
        end
        repeat (gap) begin
            i_enable_pipeline = 1'b0;
            i_instr_valid     = 1'b0;
            stalled++;
            @(negedge i_clock);
        end
        i_enable_pipeline = 1'b1;
        i_instr_valid     = 1'b1;
        i_instr           = instr;
        issued++;
        if (model_exec(instr, dest, value)) begin
            exp_dest_q.push_back(dest);
            exp_data_q.push_back(value);
            exp_name_q.push_back($sformatf("%s #%0d", test_name, issued));
        end
        @(negedge i_clock);
        i_instr_valid = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge i_clock);
    endtask

    //////////////////////////////
    // Writeback compare.
    //////////////////////////////

    always @(posedge i_clock) begin : compare_writeback
        string                  name;
        mips_isa_pkg::reg_idx_t dest;
        mips_isa_pkg::word_t    data;
        if (i_soft_reset && i_enable_pipeline && o_wb_valid) begin
            if (exp_dest_q.size() == 0) begin
                $display("Writeback to r%0d at %0t when no writeback was expected",
                         o_wb_dest, $time);
                other_errors++;
            end else begin
                name = exp_name_q.pop_front();
                dest = exp_dest_q.pop_front();
                data = exp_data_q.pop_front();
                check_dest(name, dest, o_wb_dest);
                check_data(name, data, o_wb_data);
            end
        end
        if (i_soft_reset && o_halt && !halt_issued) begin
            $display("o_halt went high at %0t before any halt was issued", $time);
            other_errors++;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 4 + issued + stalled + 20) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("Timeout after %0d cycles without reaching the halt", cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        seed              = 32'ha116_d59b;
        issued            = 0;
        stalled           = 0;
        mismatches        = 0;
        other_errors      = 0;
        stall_on          = 1'b0;
        halt_issued       = 1'b0;
        i_soft_reset      = 1'b0;
        i_enable_pipeline = 1'b1;
        i_instr_valid     = 1'b0;
        i_instr           = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (4) @(posedge i_clock);
        @(negedge i_clock);
        i_soft_reset = 1'b1;

        test_name = "immediates";
        for (int r = 1; r <= 8; r++) begin
            issue(i_format(mips_isa_pkg::OP_LUI, mips_isa_pkg::reg_idx_t'(r), 0,
                           mips_isa_pkg::imm16_t'($random(seed))));
            issue(i_format(mips_isa_pkg::OP_ORI, mips_isa_pkg::reg_idx_t'(r),
                           mips_isa_pkg::reg_idx_t'(r), mips_isa_pkg::imm16_t'($random(seed))));
        end
        for (int i = 0; i < 18; i++) begin
            issue(i_format(imm_ops[i % 6], pick_reg(), pick_reg(),
                           mips_isa_pkg::imm16_t'($random(seed))));
        end

        test_name = "r_type";
        for (int i = 0; i < 36; i++) begin
            issue(r_format(functs[i % 9], pick_reg(), pick_reg(), pick_reg()));
        end

        test_name = "forwarding";
        issue(r_format(mips_isa_pkg::FN_ADDU, 16, 1, 2));
        issue(r_format(mips_isa_pkg::FN_ADDU, 17, 16, 3));
        issue(r_format(mips_isa_pkg::FN_XOR, 18, 16, 17));
        issue(r_format(mips_isa_pkg::FN_OR, 19, 16, 18));
        issue(i_format(mips_isa_pkg::OP_ADDI, 21, 1, 16'h0005));
        issue(i_format(mips_isa_pkg::OP_ADDI, 21, 2, 16'hfff9));
        issue(r_format(mips_isa_pkg::FN_SUBU, 22, 21, 19));

        test_name = "memory";
        issue(i_format(mips_isa_pkg::OP_ADDI, 20, 0, 16'h0040));
        issue(i_format(mips_isa_pkg::OP_SW, 1, 20, 16'h0000));
        issue(i_format(mips_isa_pkg::OP_SW, 2, 20, 16'h0008));
        issue(i_format(mips_isa_pkg::OP_SW, 3, 20, 16'hfffc));
        issue(i_format(mips_isa_pkg::OP_LW, 23, 20, 16'h0008));
        issue(i_format(mips_isa_pkg::OP_LW, 24, 20, 16'h0000));
        issue(i_format(mips_isa_pkg::OP_LW, 25, 20, 16'hfffc));
        issue(r_format(mips_isa_pkg::FN_ADDU, 26, 23, 24));
        issue(i_format(mips_isa_pkg::OP_ADDI, 27, 0, 16'h1234));
        issue(i_format(mips_isa_pkg::OP_SW, 27, 20, 16'h000c));
        issue(i_format(mips_isa_pkg::OP_LW, 28, 20, 16'h000c));
        for (int i = 0; i < 8; i++) begin
            mips_isa_pkg::imm16_t offset;
            offset = mips_isa_pkg::imm16_t'(($unsigned($random(seed)) % 16) * 4);
            issue(i_format(mips_isa_pkg::OP_SW, pick_reg(), 20, offset));
            issue(i_format(mips_isa_pkg::OP_LW, 24, 20, offset));
        end
        idle(2);

        test_name = "register_zero";
        issue(r_format(mips_isa_pkg::FN_ADDU, 0, 1, 2));
        issue(i_format(mips_isa_pkg::OP_ADDI, 0, 0, 16'h0037));
        issue(r_format(mips_isa_pkg::FN_OR, 29, 0, 0));
        issue(i_format(mips_isa_pkg::OP_ADDI, 30, 0, 16'hffff));

        test_name = "stall";
        stall_on = 1'b1;
        for (int i = 0; i < 30; i++) begin
            if (i % 2 == 0) begin
                issue(r_format(functs[$unsigned($random(seed)) % 9], pick_reg(), pick_reg(),
                               pick_reg()));
            end else begin
                issue(i_format(imm_ops[$unsigned($random(seed)) % 6], pick_reg(), pick_reg(),
                               mips_isa_pkg::imm16_t'($random(seed))));
            end
        end
        stall_on = 1'b0;

        // The halt closes the program; all writebacks must drain before it.
        test_name   = "halt";
        halt_issued = 1'b1;
        issue({mips_isa_pkg::OP_HALT, 26'd0});
        @(posedge i_clock);
        while (!o_halt) @(posedge i_clock);
        if (exp_dest_q.size() != 0) begin
            $display("%0d expected writebacks were still missing when o_halt rose",
                     exp_dest_q.size());
            other_errors++;
        end

        $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- mips_exec_pipeline.f
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/forwarding_unit.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/mips_exec_pipeline.sv
testbench/tb_mips_exec_pipeline.sv
